// ==== flist.f ====
src/pcs_rx_pkg.sv
src/block_lock_fsm.sv
src/ber_window_timer.sv
src/rx_descrambler.sv
src/rx_block_decoder.sv
src/pcs_rx_top.sv
tb/tb_pcs_rx.sv

// ==== Makefile ====
TOP = tb_pcs_rx

.PHONY: all lint clean

all:
	verilator --binary --timing --timescale 1ns/100ps -f flist.f --top-module $(TOP) \
		--Mdir obj_dir -o sim
	out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "No errors"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f flist.f \
		--top-module pcs_rx_top

clean:
	rm -rf obj_dir

// ==== tb/tb_pcs_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pcs_rx;

    localparam int CLK_PERIOD = 10;
    localparam logic [31:0] SEED = 32'hbe20_bc96;

    // First idles fall in the slip wait behind one invalid block still in flight
    localparam int LOCK_AT = pcs_rx_pkg::SLIP_WAIT_CYCLES - 1 + pcs_rx_pkg::LOCK_GOOD_COUNT;

    // Rough test lengths in cycles
    localparam int ACQUIRE_LEN  = 5 * (pcs_rx_pkg::SLIP_WAIT_CYCLES + 2) + LOCK_AT + 16;
    localparam int DECODE_LEN   = 12 * 8 + 32;
    localparam int HIGH_BER_LEN = 4 * pcs_rx_pkg::BER_WINDOW;
    localparam int LOSE_LEN     = 2 * pcs_rx_pkg::LOCK_WINDOW;
    localparam int RUN_CYCLES   = 4 * (ACQUIRE_LEN + DECODE_LEN + HIGH_BER_LEN + LOSE_LEN) + 1000;

    localparam logic [63:0] IDLE_PAYLOAD = {56'h0, pcs_rx_pkg::BT_CTRL};
    localparam pcs_rx_pkg::xgmii_t IDLE_BEAT  = '{d: {8{pcs_rx_pkg::XG_IDLE}}, c: 8'hff};
    localparam pcs_rx_pkg::xgmii_t ERROR_BEAT = '{d: {8{pcs_rx_pkg::XG_ERROR}}, c: 8'hff};

    localparam logic [7:0] TERM_TYPE [8] = '{
        pcs_rx_pkg::BT_TERM0, pcs_rx_pkg::BT_TERM1, pcs_rx_pkg::BT_TERM2, pcs_rx_pkg::BT_TERM3,
        pcs_rx_pkg::BT_TERM4, pcs_rx_pkg::BT_TERM5, pcs_rx_pkg::BT_TERM6, pcs_rx_pkg::BT_TERM7
    };
    // Ordered set and lane 4 start types followed by an unassigned code
    localparam logic [7:0] BAD_TYPE [5] = '{8'h2d, 8'h33, 8'h4b, 8'h55, 8'h00};

    logic                  gt_rxusrclk = 1'b0;
    logic                  gt_tx_reset;
    pcs_rx_pkg::rx_block_t serdes_rx;
    logic                  serdes_rx_bitslip;
    pcs_rx_pkg::xgmii_t    xgmii_rx;
    logic                  rx_block_lock;
    logic                  rx_high_ber;

    // Scrambler history with the newest scrambled bit in bit 0
    logic [57:0]        scr_hist = '1;
    pcs_rx_pkg::xgmii_t exp_q[$];
    int                 cycle_count;
    int                 lock_cycle;
    logic               lock_seen;

    pcs_rx_top i_dut (
        .gt_rxusrclk       (gt_rxusrclk),
        .gt_tx_reset       (gt_tx_reset),
        .serdes_rx         (serdes_rx),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .xgmii_rx          (xgmii_rx),
        .rx_block_lock     (rx_block_lock),
        .rx_high_ber       (rx_high_ber)
    );

    always #(CLK_PERIOD / 2) gt_rxusrclk = ~gt_rxusrclk;

    always @(posedge gt_rxusrclk) begin
        if (gt_tx_reset) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    // Cycle of the first lock which marks the 64-header groups
    always @(negedge gt_rxusrclk) begin
        if (rx_block_lock && !lock_seen) begin
            lock_cycle <= cycle_count;
        end
        lock_seen <= rx_block_lock;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_xgmii(input string name, input pcs_rx_pkg::xgmii_t exp,
                               input pcs_rx_pkg::xgmii_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected d=%h c=%h, actual d=%h c=%h",
                     name, exp.d, exp.c, act.d, act.c);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // Scrambler x^58 + x^39 + 1 applied from the LSB up
    task automatic scramble(input logic [63:0] plain, output logic [63:0] scr);
        logic s;
        for (int i = 0; i < 64; i++) begin
            s = plain[i] ^ scr_hist[38] ^ scr_hist[57];
            scr[i] = s;
            scr_hist = {scr_hist[56:0], s};
        end
    endtask

    // Returns at the following falling edge where outputs are stable
    task automatic send_block(input logic [1:0] hdr, input logic [63:0] payload);
        pcs_rx_pkg::rx_block_t blk;
        logic [63:0]           scr;
        scramble(payload, scr);
        blk.hdr  = hdr;
        blk.data = scr;
        @(posedge gt_rxusrclk);
        serdes_rx <= blk;
        @(negedge gt_rxusrclk);
    endtask

    task automatic send_idle();
        send_block(pcs_rx_pkg::SYNC_CTRL, IDLE_PAYLOAD);
    endtask

    // The beat on the output now belongs to the block sent two calls ago
    task automatic send_expect(input string name, input logic [1:0] hdr,
                               input logic [63:0] payload, input pcs_rx_pkg::xgmii_t exp);
        send_block(hdr, payload);
        if (exp_q.size() == 2) begin
            check_xgmii(name, exp_q.pop_front(), xgmii_rx);
        end
        exp_q.push_back(exp);
    endtask

    task automatic drain_expect(input string name);
        repeat (2) begin
            send_expect(name, pcs_rx_pkg::SYNC_CTRL, IDLE_PAYLOAD, IDLE_BEAT);
        end
        exp_q.delete();
    endtask

    task automatic test_reset();
        repeat (5) @(posedge gt_rxusrclk);
        gt_tx_reset <= 1'b0;
        @(negedge gt_rxusrclk);
        check_bit("reset bitslip", 1'b0, serdes_rx_bitslip);
        check_bit("reset lock", 1'b0, rx_block_lock);
        check_bit("reset high_ber", 1'b0, rx_high_ber);
        check_xgmii("reset output", pcs_rx_pkg::LOCAL_FAULT, xgmii_rx);
    endtask

    task automatic test_acquire_lock();
        int slips_left;
        slips_left = 1 + ($urandom % 5);
        while (slips_left > 0) begin
            send_block(($urandom % 2 == 0) ? 2'b00 : 2'b11, {$urandom, $urandom});
            if (serdes_rx_bitslip) begin
                slips_left--;
            end
        end
        for (int n = 1; n <= LOCK_AT + 8; n++) begin
            send_idle();
            check_bit("acquire_lock bitslip", 1'b0, serdes_rx_bitslip);
            check_bit("acquire_lock lock", n > LOCK_AT, rx_block_lock);
            if (n > LOCK_AT + 1) begin
                check_xgmii("acquire_lock idle", IDLE_BEAT, xgmii_rx);
            end else begin
                check_xgmii("acquire_lock fault", pcs_rx_pkg::LOCAL_FAULT, xgmii_rx);
            end
        end
    endtask

    task automatic test_frame_decode();
        logic [63:0]        r;
        pcs_rx_pkg::xgmii_t exp;
        int                 k;
        check_bit("frame_decode lock", 1'b1, rx_block_lock);
        send_expect("frame_decode", pcs_rx_pkg::SYNC_CTRL, IDLE_PAYLOAD, IDLE_BEAT);
        for (int f = 0; f < 12; f++) begin
            r = {$urandom, $urandom};
            exp.d = {r[63:8], pcs_rx_pkg::XG_START};
            exp.c = 8'h01;
            send_expect("frame_decode start", pcs_rx_pkg::SYNC_CTRL,
                        {r[63:8], pcs_rx_pkg::BT_START}, exp);
            repeat (1 + ($urandom % 4)) begin
                r = {$urandom, $urandom};
                exp.d = r;
                exp.c = 8'h00;
                send_expect("frame_decode data", pcs_rx_pkg::SYNC_DATA, r, exp);
            end
            k = $urandom % 8;
            r = {$urandom, $urandom};
            for (int i = 0; i < 8; i++) begin
                if (i < k) begin
                    exp.d[8*i +: 8] = r[8*(i+1) +: 8];
                    exp.c[i] = 1'b0;
                end else if (i == k) begin
                    exp.d[8*i +: 8] = pcs_rx_pkg::XG_TERM;
                    exp.c[i] = 1'b1;
                end else begin
                    exp.d[8*i +: 8] = pcs_rx_pkg::XG_IDLE;
                    exp.c[i] = 1'b1;
                end
            end
            send_expect("frame_decode term", pcs_rx_pkg::SYNC_CTRL, {r[63:8], TERM_TYPE[k]}, exp);
            send_expect("frame_decode idle", pcs_rx_pkg::SYNC_CTRL, IDLE_PAYLOAD, IDLE_BEAT);
        end
        drain_expect("frame_decode");
    endtask

    task automatic test_error_block();
        logic [63:0] r;
        check_bit("error_block lock", 1'b1, rx_block_lock);
        send_expect("error_block", pcs_rx_pkg::SYNC_CTRL, IDLE_PAYLOAD, IDLE_BEAT);
        for (int i = 0; i < 5; i++) begin
            r = {$urandom, $urandom};
            send_expect("error_block", pcs_rx_pkg::SYNC_CTRL, {r[63:8], BAD_TYPE[i]}, ERROR_BEAT);
            send_expect("error_block idle", pcs_rx_pkg::SYNC_CTRL, IDLE_PAYLOAD, IDLE_BEAT);
        end
        drain_expect("error_block");
    endtask

    task automatic test_high_ber();
        // Keep the burst inside one BER window
        while ((cycle_count % pcs_rx_pkg::BER_WINDOW) != 16) begin
            send_idle();
        end
        for (int b = 0; b < 5 * pcs_rx_pkg::BER_BAD_LIMIT; b++) begin
            send_block((b % 5 == 4) ? 2'b00 : pcs_rx_pkg::SYNC_CTRL, IDLE_PAYLOAD);
            check_bit("high_ber early", 1'b0, rx_high_ber);
            check_bit("high_ber lock", 1'b1, rx_block_lock);
        end
        send_idle();
        check_bit("high_ber set", 1'b1, rx_high_ber);
        check_bit("high_ber lock", 1'b1, rx_block_lock);
        send_idle();
        check_xgmii("high_ber fault", pcs_rx_pkg::LOCAL_FAULT, xgmii_rx);
        repeat (2 * pcs_rx_pkg::BER_WINDOW) begin
            send_idle();
            check_bit("high_ber lock", 1'b1, rx_block_lock);
        end
        check_bit("high_ber clear", 1'b0, rx_high_ber);
        check_xgmii("high_ber idle", IDLE_BEAT, xgmii_rx);
    endtask

    task automatic test_lose_lock();
        // The next block is sampled two edges on and opens the burst in the second slot of a group
        while (((cycle_count + 2 - lock_cycle) % pcs_rx_pkg::LOCK_WINDOW) != 2) begin
            send_idle();
        end
        for (int b = 0; b < pcs_rx_pkg::LOCK_BAD_LIMIT; b++) begin
            send_block(2'b11, IDLE_PAYLOAD);
            check_bit("lose_lock early", 1'b1, rx_block_lock);
        end
        send_idle();
        check_bit("lose_lock drop", 1'b0, rx_block_lock);
        check_bit("lose_lock bitslip", 1'b0, serdes_rx_bitslip);
        send_idle();
        check_xgmii("lose_lock fault", pcs_rx_pkg::LOCAL_FAULT, xgmii_rx);
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        abort_run();
    end

    initial begin
        void'($urandom(SEED));
        gt_tx_reset = 1'b1;
        serdes_rx = '{hdr: 2'b00, data: 64'h0};
        test_reset();
        test_acquire_lock();
        test_frame_decode();
        test_error_block();
        test_high_ber();
        test_lose_lock();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/pcs_rx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcs_rx_top (
    input  wire                   gt_rxusrclk,
    input  wire                   gt_tx_reset,
    input  wire pcs_rx_pkg::rx_block_t serdes_rx,
    output logic                  serdes_rx_bitslip,
    output pcs_rx_pkg::xgmii_t    xgmii_rx,
    output logic                  rx_block_lock,
    output logic                  rx_high_ber
);

    // Descrambled block, one cycle behind the input
    pcs_rx_pkg::rx_block_t descr_block;

    block_lock_fsm block_lock_inst (
        .gt_rxusrclk       (gt_rxusrclk),
        .gt_tx_reset       (gt_tx_reset),
        .hdr               (serdes_rx.hdr),
        .rx_block_lock     (rx_block_lock),
        .serdes_rx_bitslip (serdes_rx_bitslip)
    );

    ber_window_timer ber_inst (
        .gt_rxusrclk   (gt_rxusrclk),
        .gt_tx_reset   (gt_tx_reset),
        .hdr           (serdes_rx.hdr),
        .rx_block_lock (rx_block_lock),
        .rx_high_ber   (rx_high_ber)
    );

    rx_descrambler descrambler_inst (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .serdes_rx   (serdes_rx),
        .descr_block (descr_block)
    );

    rx_block_decoder decoder_inst (
        .gt_rxusrclk   (gt_rxusrclk),
        .gt_tx_reset   (gt_tx_reset),
        .descr_block   (descr_block),
        .rx_block_lock (rx_block_lock),
        .rx_high_ber   (rx_high_ber),
        .xgmii_rx      (xgmii_rx)
    );

endmodule

`default_nettype wire

// ==== src/rx_block_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_block_decoder (
    input  wire                   gt_rxusrclk,
    input  wire                   gt_tx_reset,
    input  wire pcs_rx_pkg::rx_block_t descr_block,
    input  wire                   rx_block_lock,
    input  wire                   rx_high_ber,
    output pcs_rx_pkg::xgmii_t    xgmii_rx
);

    pcs_rx_pkg::block_type_e blk_type;
    pcs_rx_pkg::xgmii_t      dec;

    logic [63:0] payload;
    logic [2:0]  term_k;
    logic        is_term;

    assign blk_type = pcs_rx_pkg::block_type_e'(descr_block.data[7:0]);

    // Payload bytes 1 to 7 moved down to lanes 0 to 6
    assign payload = {8'h00, descr_block.data[63:8]};

    // Terminate lane from the block type
    always_comb begin
        is_term = 1'b1;
        term_k  = 3'd0;
        case (blk_type)
            pcs_rx_pkg::BT_TERM0: term_k = 3'd0;
            pcs_rx_pkg::BT_TERM1: term_k = 3'd1;
            pcs_rx_pkg::BT_TERM2: term_k = 3'd2;
            pcs_rx_pkg::BT_TERM3: term_k = 3'd3;
            pcs_rx_pkg::BT_TERM4: term_k = 3'd4;
            pcs_rx_pkg::BT_TERM5: term_k = 3'd5;
            pcs_rx_pkg::BT_TERM6: term_k = 3'd6;
            pcs_rx_pkg::BT_TERM7: term_k = 3'd7;
            default:              is_term = 1'b0;
        endcase
    end

    always_comb begin
        // Error block unless something below matches
        dec.d = {8{pcs_rx_pkg::XG_ERROR}};
        dec.c = 8'hff;

        if (descr_block.hdr == pcs_rx_pkg::SYNC_DATA) begin
            dec.d = descr_block.data;
            dec.c = 8'h00;
        end else if (descr_block.hdr == pcs_rx_pkg::SYNC_CTRL) begin
            if (blk_type == pcs_rx_pkg::BT_CTRL) begin
                dec.d = {8{pcs_rx_pkg::XG_IDLE}};
                dec.c = 8'hff;
            end else if (blk_type == pcs_rx_pkg::BT_START) begin
                dec.d = {descr_block.data[63:8], pcs_rx_pkg::XG_START};
                dec.c = 8'h01;
            end else if (is_term) begin
                for (int i = 0; i < 8; i++) begin
                    if (3'(i) < term_k) begin
                        dec.d[8*i +: 8] = payload[8*i +: 8];
                        dec.c[i]        = 1'b0;
                    end else if (3'(i) == term_k) begin
                        dec.d[8*i +: 8] = pcs_rx_pkg::XG_TERM;
                        dec.c[i]        = 1'b1;
                    end else begin
                        dec.d[8*i +: 8] = pcs_rx_pkg::XG_IDLE;
                        dec.c[i]        = 1'b1;
                    end
                end
            end
        end
    end

    // Local fault while unaligned or the link is too noisy
    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            xgmii_rx <= pcs_rx_pkg::LOCAL_FAULT;
        end else if (!rx_block_lock || rx_high_ber) begin
            xgmii_rx <= pcs_rx_pkg::LOCAL_FAULT;
        end else begin
            xgmii_rx <= dec;
        end
    end

endmodule

`default_nettype wire

// ==== src/rx_descrambler.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_descrambler (
    input  wire                   gt_rxusrclk,
    input  wire                   gt_tx_reset,
    input  wire pcs_rx_pkg::rx_block_t serdes_rx,
    output pcs_rx_pkg::rx_block_t descr_block
);

    // scr_state[57] is the most recent received bit, scr_state[0] the oldest
    logic [57:0]  scr_state;
    logic [121:0] scr_ext;
    logic [63:0]  descr_data;

    // Received bit i sits at scr_ext[58+i]
    assign scr_ext = {serdes_rx.data, scr_state};

    // Taps at 39 and 58 bits back, x^58 + x^39 + 1
    assign descr_data = scr_ext[121:58] ^ scr_ext[82:19] ^ scr_ext[63:0];

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            scr_state <= '0;
        end else begin
            scr_state <= serdes_rx.data[63:6];
        end
    end

    // Header is delayed alongside its payload
    always_ff @(posedge gt_rxusrclk) begin
        descr_block.hdr  <= serdes_rx.hdr;
        descr_block.data <= descr_data;
    end

endmodule

`default_nettype wire

// ==== src/ber_window_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module ber_window_timer (
    input  wire        gt_rxusrclk,
    input  wire        gt_tx_reset,
    input  wire  [1:0] hdr,
    input  wire        rx_block_lock,
    output logic       rx_high_ber
);

    logic [pcs_rx_pkg::BER_TIMER_W-1:0] timer;
    logic [pcs_rx_pkg::BER_COUNT_W-1:0] bad_count;
    logic [pcs_rx_pkg::BER_COUNT_W-1:0] bad_next;
    logic                               bad_hdr;
    logic                               window_end;

    // Only count errors once aligned
    assign bad_hdr = rx_block_lock &&
                     (hdr != pcs_rx_pkg::SYNC_DATA) && (hdr != pcs_rx_pkg::SYNC_CTRL);

    assign window_end = (timer == pcs_rx_pkg::BER_TIMER_LAST);

    // Saturates at the limit
    always_comb begin
        bad_next = bad_count;
        if (bad_hdr && bad_count != pcs_rx_pkg::BER_COUNT_LIMIT) begin
            bad_next = bad_count + 1'b1;
        end
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            timer       <= '0;
            bad_count   <= '0;
            rx_high_ber <= 1'b0;
        end else begin
            if (window_end) begin
                timer     <= '0;
                bad_count <= '0;
                // Flag survives the window only if the limit was hit in it
                rx_high_ber <= (bad_next == pcs_rx_pkg::BER_COUNT_LIMIT);
            end else begin
                timer     <= timer + 1'b1;
                bad_count <= bad_next;
                if (bad_next == pcs_rx_pkg::BER_COUNT_LIMIT) begin
                    rx_high_ber <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/block_lock_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_lock_fsm (
    input  wire        gt_rxusrclk,
    input  wire        gt_tx_reset,
    input  wire  [1:0] hdr,
    output logic       rx_block_lock,
    output logic       serdes_rx_bitslip
);

    pcs_rx_pkg::lock_state_e state;

    logic [pcs_rx_pkg::LOCK_GOOD_W-1:0] good_count;
    logic [pcs_rx_pkg::LOCK_WIN_W-1:0]  win_count;
    logic [pcs_rx_pkg::LOCK_BAD_W-1:0]  bad_count;
    logic [pcs_rx_pkg::SLIP_WAIT_W-1:0] wait_count;
    logic                               hdr_valid;

    assign hdr_valid = (hdr == pcs_rx_pkg::SYNC_DATA) || (hdr == pcs_rx_pkg::SYNC_CTRL);

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            state             <= pcs_rx_pkg::LOCK_SEARCH;
            good_count        <= '0;
            win_count         <= '0;
            bad_count         <= '0;
            wait_count        <= '0;
            rx_block_lock     <= 1'b0;
            serdes_rx_bitslip <= 1'b0;
        end else begin
            // Slip is a single-cycle pulse
            serdes_rx_bitslip <= 1'b0;

            case (state)
                pcs_rx_pkg::LOCK_SEARCH: begin
                    if (hdr_valid) begin
                        good_count <= pcs_rx_pkg::LOCK_GOOD_FIRST;
                        state      <= pcs_rx_pkg::LOCK_TEST;
                    end else begin
                        serdes_rx_bitslip <= 1'b1;
                        wait_count        <= '0;
                        state             <= pcs_rx_pkg::LOCK_SLIP_WAIT;
                    end
                end

                // Gearbox output is unreliable right after a slip
                pcs_rx_pkg::LOCK_SLIP_WAIT: begin
                    if (wait_count == pcs_rx_pkg::SLIP_WAIT_LAST) begin
                        state <= pcs_rx_pkg::LOCK_SEARCH;
                    end else begin
                        wait_count <= wait_count + 1'b1;
                    end
                end

                pcs_rx_pkg::LOCK_TEST: begin
                    if (!hdr_valid) begin
                        serdes_rx_bitslip <= 1'b1;
                        wait_count        <= '0;
                        state             <= pcs_rx_pkg::LOCK_SLIP_WAIT;
                    end else if (good_count == pcs_rx_pkg::LOCK_GOOD_LAST) begin
                        rx_block_lock <= 1'b1;
                        win_count     <= '0;
                        bad_count     <= '0;
                        state         <= pcs_rx_pkg::LOCK_LOCKED;
                    end else begin
                        good_count <= good_count + 1'b1;
                    end
                end

                pcs_rx_pkg::LOCK_LOCKED: begin
                    if (!hdr_valid && bad_count == pcs_rx_pkg::LOCK_BAD_LAST) begin
                        // Too many bad headers in this group, search again without a slip
                        rx_block_lock <= 1'b0;
                        state         <= pcs_rx_pkg::LOCK_SEARCH;
                    end else if (win_count == pcs_rx_pkg::LOCK_WIN_LAST) begin
                        win_count <= '0;
                        bad_count <= '0;
                    end else begin
                        win_count <= win_count + 1'b1;
                        if (!hdr_valid) begin
                            bad_count <= bad_count + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/pcs_rx_pkg.sv ====
`default_nettype none

package pcs_rx_pkg;

    // Valid sync headers, 00 and 11 are invalid
    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    // Block lock acquisition and loss
    localparam int LOCK_GOOD_COUNT  = 64;
    localparam int LOCK_WINDOW      = 64;
    localparam int LOCK_BAD_LIMIT   = 16;
    localparam int SLIP_WAIT_CYCLES = 4;

    localparam int LOCK_GOOD_W = $clog2(LOCK_GOOD_COUNT);
    localparam int LOCK_WIN_W  = $clog2(LOCK_WINDOW);
    localparam int LOCK_BAD_W  = $clog2(LOCK_BAD_LIMIT);
    localparam int SLIP_WAIT_W = $clog2(SLIP_WAIT_CYCLES);

    localparam logic [LOCK_GOOD_W-1:0] LOCK_GOOD_FIRST = LOCK_GOOD_W'(1);
    localparam logic [LOCK_GOOD_W-1:0] LOCK_GOOD_LAST  = LOCK_GOOD_W'(LOCK_GOOD_COUNT - 1);
    localparam logic [LOCK_WIN_W-1:0]  LOCK_WIN_LAST   = LOCK_WIN_W'(LOCK_WINDOW - 1);
    localparam logic [LOCK_BAD_W-1:0]  LOCK_BAD_LAST   = LOCK_BAD_W'(LOCK_BAD_LIMIT - 1);
    localparam logic [SLIP_WAIT_W-1:0] SLIP_WAIT_LAST  = SLIP_WAIT_W'(SLIP_WAIT_CYCLES - 1);

    // BER monitor, window shortened for simulation
    localparam int BER_WINDOW    = 1024;
    localparam int BER_BAD_LIMIT = 16;

    localparam int BER_TIMER_W = $clog2(BER_WINDOW);
    localparam int BER_COUNT_W = $clog2(BER_BAD_LIMIT + 1);

    localparam logic [BER_TIMER_W-1:0] BER_TIMER_LAST  = BER_TIMER_W'(BER_WINDOW - 1);
    localparam logic [BER_COUNT_W-1:0] BER_COUNT_LIMIT = BER_COUNT_W'(BER_BAD_LIMIT);

    // XGMII characters
    localparam logic [7:0] XG_IDLE    = 8'h07;
    localparam logic [7:0] XG_START   = 8'hfb;
    localparam logic [7:0] XG_TERM    = 8'hfd;
    localparam logic [7:0] XG_ERROR   = 8'hfe;
    localparam logic [7:0] XG_SEQ     = 8'h9c;
    localparam logic [7:0] XG_LF_CODE = 8'h01;

    typedef struct packed {
        logic [1:0]  hdr;
        logic [63:0] data;
    } rx_block_t;

    // Lane 0 sits in d[7:0] and c[0]
    typedef struct packed {
        logic [63:0] d;
        logic [7:0]  c;
    } xgmii_t;

    typedef enum logic [1:0] {
        LOCK_SEARCH,
        LOCK_SLIP_WAIT,
        LOCK_TEST,
        LOCK_LOCKED
    } lock_state_e;

    typedef enum logic [7:0] {
        BT_CTRL  = 8'h1e,
        BT_START = 8'h78,
        BT_TERM0 = 8'h87,
        BT_TERM1 = 8'h99,
        BT_TERM2 = 8'haa,
        BT_TERM3 = 8'hb4,
        BT_TERM4 = 8'hcc,
        BT_TERM5 = 8'hd2,
        BT_TERM6 = 8'he1,
        BT_TERM7 = 8'hff
    } block_type_e;

    // Sequence ordered set carrying local fault in both columns
    localparam xgmii_t LOCAL_FAULT = '{
        d: {XG_LF_CODE, 8'h00, 8'h00, XG_SEQ, XG_LF_CODE, 8'h00, 8'h00, XG_SEQ},
        c: 8'h11
    };

endpackage

`default_nettype wire
